/* Makefile */
# Verilator build of the FMA pipe testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_fma_pipe
FILELIST = fma_pipe.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fma_checker.sv */
// FMA pipe result checker
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_checker
  (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   flush_i,
    input logic                   issue_v_i,
    input logic [2:0]             issue_op_i,
    input logic [2:0]             issue_fn_i,
    input logic [2:0]             frm_dyn_i,
    input logic [`FMA_XLEN-1:0]   rs1_i,
    input logic [`FMA_XLEN-1:0]   rs2_i,
    input logic [`FMA_XLEN-1:0]   rs3_i,
    input logic [3:0]             test_id_i,
    input logic                   imul_v_i,
    input logic [`FMA_XLEN-1:0]   imul_data_i,
    input logic                   fma_v_i,
    input logic [`FMA_HALF_W-1:0] fma_data_i,
    input logic [4:0]             fma_fflags_i
  );
  import fma_pkg::*;

  typedef struct packed {
    logic [31:0] due;
    logic [3:0]  test;
    logic [31:0] value;
  } expect_s;

  expect_s imul_q[$];
  expect_s fma_q[$];
  int      cycle;
  int      checks;
  int      errors;

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd0:    return "reset_idle";
      4'd1:    return "imul";
      4'd2:    return "addsub_mul";
      4'd3:    return "fma_burst";
      4'd4:    return "special";
      default: return "flush";
    endcase
  endfunction

  // exact model where both terms are integers scaled by 2^-48 and rounded once
  function automatic logic [20:0] model_float(input logic [15:0] a, input logic [15:0] b,
                                              input logic [15:0] c, input logic np,
                                              input logic nc, input logic [2:0] rm);
    logic         a_z, b_z, c_z, a_i, b_i, c_i, a_n, b_n, c_n;
    logic         ps, cs, sgn, nv, p_inf, guard, sticky, inx, inc;
    logic [21:0]  pp;
    logic [127:0] pm, cm, mag;
    logic [11:0]  mant;
    logic [4:0]   fl;
    int           m, e;
    a_z = (a[14:10] == 5'd0);
    b_z = (b[14:10] == 5'd0);
    c_z = (c[14:10] == 5'd0);
    a_i = (a[14:0] == 15'h7C00);
    b_i = (b[14:0] == 15'h7C00);
    c_i = (c[14:0] == 15'h7C00);
    a_n = (a[14:10] == 5'h1F) && !a_i;
    b_n = (b[14:10] == 5'h1F) && !b_i;
    c_n = (c[14:10] == 5'h1F) && !c_i;
    ps = a[15] ^ b[15] ^ np;
    cs = c[15] ^ nc;
    p_inf = a_i | b_i;
    nv = (a_n & ~a[9]) | (b_n & ~b[9]) | (c_n & ~c[9]) | (a_i & b_z) | (b_i & a_z);
    nv = nv | (!(a_n | b_n | c_n) & p_inf & c_i & (ps != cs));
    if (a_n | b_n | c_n | nv)
      return {nv, 4'd0, 16'h7E00};
    if (p_inf | c_i)
      return {5'd0, p_inf ? ps : cs, 15'h7C00};
    if ((a_z | b_z) & c_z)
      return {5'd0, (ps == cs) ? ps : (rm == e_rdn), 15'h0000};
    pp = (a_z | b_z) ? 22'd0 : ({11'd0, 1'b1, a[9:0]} * {11'd0, 1'b1, b[9:0]});
    pm = {106'd0, pp} << (int'(a[14:10]) + int'(b[14:10]) - 2);
    cm = c_z ? 128'd0 : ({117'd0, 1'b1, c[9:0]} << (int'(c[14:10]) + 23));
    if (ps == cs)
    begin
      mag = pm + cm;
      sgn = ps;
    end
    else if (pm >= cm)
    begin
      mag = pm - cm;
      sgn = ps;
    end
    else
    begin
      mag = cm - pm;
      sgn = cs;
    end
    if (mag == 128'd0)
      return {5'd0, rm == e_rdn, 15'h0000};
    m = 0;
    for (int i = 0; i < 128; i++)
      if (mag[i])
        m = i;
    e = m - 33;
    mant = 12'(mag >> (m - 10));
    guard = mag[m-11];
    sticky = (mag & ((128'd1 << (m - 11)) - 128'd1)) != 128'd0;
    inx = guard | sticky;
    case (rm)
      e_rtz:   inc = 1'b0;
      e_rdn:   inc = sgn & inx;
      e_rup:   inc = ~sgn & inx;
      e_rmm:   inc = guard;
      default: inc = guard & (sticky | mant[0]);
    endcase
    mant = mant + {11'd0, inc};
    if (mant[11])
    begin
      mant = mant >> 1;
      e = e + 1;
    end
    fl = {4'd0, inx};
    if (e > 30)
    begin
      fl = 5'b00101;
      if ((rm == e_rtz) || (rm == e_rdn && !sgn) || (rm == e_rup && sgn))
        return {fl, sgn, 15'h7BFF};
      return {fl, sgn, 15'h7C00};
    end
    if (e < 1)
      return {5'b00011, sgn, 15'h0000};
    return {fl, sgn, 5'(e), mant[9:0]};
  endfunction

  task automatic compare(input expect_s item, input logic [31:0] actual, input string kind);
    checks++;
    if (item.due != 32'(cycle))
    begin
      errors++;
      $display("Error: test %s, %s result came at cycle %0d instead of cycle %0d",
               test_name(item.test), kind, cycle, item.due);
    end
    else if (item.value != actual)
    begin
      errors++;
      $display("Error: test %s, %s expected %h, actual %h",
               test_name(item.test), kind, item.value, actual);
    end
  endtask

  task automatic push_issue();
    expect_s     item;
    logic [15:0] b, c;
    logic [2:0]  rm;
    logic [31:0] p;
    item.test = test_id_i;
    if (issue_op_i == e_imul)
    begin
      p = rs1_i * rs2_i;
      item.due = 32'(cycle + `IMUL_LATENCY);
      item.value = issue_fn_i[2] ? {{16{p[15]}}, p[15:0]} : p;
      imul_q.push_back(item);
    end
    else
    begin
      rm = (issue_fn_i == 3'd7) ? frm_dyn_i : issue_fn_i;
      b = rs2_i[15:0];
      c = rs3_i[15:0];
      if (issue_op_i == e_fadd || issue_op_i == e_fsub)
      begin
        b = 16'h3C00;
        c = rs2_i[15:0];
      end
      else if (issue_op_i == e_fmul)
        c = 16'h0000;
      item.due = 32'(cycle + `FMA_LATENCY);
      item.value = {11'd0, model_float(rs1_i[15:0], b, c,
                   issue_op_i == e_fnmsub || issue_op_i == e_fnmadd,
                   issue_op_i == e_fsub || issue_op_i == e_fmsub || issue_op_i == e_fnmadd, rm)};
      fma_q.push_back(item);
    end
  endtask

  initial
  begin
    cycle = 0;
    checks = 0;
    errors = 0;
  end

  // outputs are sampled before this edge updates them
  always @(posedge clk_i)
  begin
    if (imul_v_i)
    begin
      if (imul_q.size() == 0)
      begin
        errors++;
        $display("Error: test %s, integer valid rose with nothing in flight",
                 test_name(test_id_i));
      end
      else
        compare(imul_q.pop_front(), imul_data_i, "integer");
    end
    else if (imul_q.size() != 0 && imul_q[0].due < 32'(cycle))
      compare(imul_q.pop_front(), 32'hx, "integer");
    if (fma_v_i)
    begin
      if (fma_q.size() == 0)
      begin
        errors++;
        $display("Error: test %s, float valid rose with nothing in flight",
                 test_name(test_id_i));
      end
      else
        compare(fma_q.pop_front(), {11'd0, fma_fflags_i, fma_data_i}, "float");
    end
    else if (fma_q.size() != 0 && fma_q[0].due < 32'(cycle))
      compare(fma_q.pop_front(), 32'hx, "float");
    // nothing has been issued yet so both valids must be a clean low
    if (test_id_i == 4'd0 && !reset_i)
    begin
      checks++;
      if (imul_v_i !== 1'b0 || fma_v_i !== 1'b0)
      begin
        errors++;
        $display("Error: test %s, a result valid was not low after reset",
                 test_name(test_id_i));
      end
    end
    // a flush drops everything in flight and the issue of the same cycle
    if (flush_i)
    begin
      imul_q.delete();
      fma_q.delete();
    end
    else if (issue_v_i && !reset_i)
      push_issue();
    cycle++;
  end

endmodule

/* bench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen
  (
    output logic clk_o,
    output logic reset_o
  );

  // 40 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // reset is held over the first 8 rising edges
  initial
  begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* bench/tb_fma_pipe.sv */
// FMA pipe testbench
`timescale 1ns/1ps
`include "fma_params.svh"

module tb_fma_pipe;
  import fma_pkg::*;

  localparam int TOTAL_ISSUES = 253;
  localparam int CLK_PERIOD   = 40;

  logic         clk, reset, flush, issue_v;
  fma_op_e      op;
  fma_instr_u   fn;
  fma_rm_e      frm;
  logic [31:0]  rs1, rs2, rs3, imul_data, rng_state;
  logic [15:0]  fma_data;
  logic [3:0]   test_id;
  logic         imul_v, fma_v;
  fma_fflags_s  fflags;
  int           checks_before, errors_before;

  tb_clock_gen u_clk (.clk_o(clk), .reset_o(reset));

  fma_pipe_top UUT
    (
      .clk_i(clk), .reset_i(reset), .flush_i(flush), .issue_v_i(issue_v),
      .issue_op_i(op), .issue_fn_i(fn), .frm_dyn_i(frm),
      .rs1_i(rs1), .rs2_i(rs2), .rs3_i(rs3),
      .imul_data_o(imul_data), .imul_v_o(imul_v),
      .fma_data_o(fma_data), .fma_fflags_o(fflags), .fma_v_o(fma_v)
    );

  fma_checker u_check
    (
      .clk_i(clk), .reset_i(reset), .flush_i(flush), .issue_v_i(issue_v),
      .issue_op_i(op), .issue_fn_i(fn), .frm_dyn_i(frm),
      .rs1_i(rs1), .rs2_i(rs2), .rs3_i(rs3), .test_id_i(test_id),
      .imul_v_i(imul_v), .imul_data_i(imul_data),
      .fma_v_i(fma_v), .fma_data_i(fma_data), .fma_fflags_i(fflags)
    );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // zeros, infinities and NaNs come up often, normals sit near base
  task automatic rand_half(output logic [15:0] h, input logic [4:0] base);
    logic [31:0] r;
    next_rand(r);
    case (r[3:0])
      4'd0:    h = {r[4], 5'd0, r[15:6]};
      4'd1:    h = {r[4], 15'h7C00};
      4'd2:    h = {r[4], 5'h1F, r[5], r[14:6] | 9'd1};
      default: h = {r[4], base + 5'(r[8:6]) - 5'd3, r[25:16]};
    endcase
  endtask

  task automatic drive(input fma_op_e o, input fma_instr_u f, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] c, input fma_rm_e dyn,
                       input logic fl);
    @(negedge clk);
    issue_v = 1'b1;
    op = o;
    fn = f;
    rs1 = a;
    rs2 = b;
    rs3 = c;
    frm = dyn;
    flush = fl;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      issue_v = 1'b0;
      flush = 1'b0;
    end
  endtask

  task automatic float_op(input fma_op_e o, input logic fl);
    logic [31:0] r;
    logic [15:0] a, b, c;
    fma_instr_u  f;
    next_rand(r);
    rand_half(a, 5'd15);
    rand_half(b, 5'd15);
    rand_half(c, 5'(4 + r % 23));
    f.rm = (r[7:5] > 3'd4) ? e_dyn : fma_rm_e'(r[7:5]);
    next_rand(r);
    drive(o, f, {16'd0, a}, {16'd0, b}, {16'd0, c}, fma_rm_e'(3'(r % 5)), fl);
  endtask

  task automatic imul_op(input logic fl);
    logic [31:0] a, b, r;
    fma_instr_u  f;
    next_rand(a);
    next_rand(b);
    next_rand(r);
    f.imul = {r[0], 2'b00};
    drive(e_imul, f, a, b, 32'd0, e_rne, fl);
  endtask

  task automatic special(input fma_op_e o, input fma_rm_e rm, input logic [15:0] a,
                         input logic [15:0] b, input logic [15:0] c);
    fma_instr_u f;
    f.rm = rm;
    drive(o, f, {16'd0, a}, {16'd0, b}, {16'd0, c}, e_rne, 1'b0);
  endtask

  task automatic begin_test(input logic [3:0] id);
    test_id = id;
    checks_before = u_check.checks;
    errors_before = u_check.errors;
  endtask

  // the drain length follows from the fixed float latency
  task automatic end_test(input string name);
    idle(`FMA_LATENCY + 2);
    $display("test %s: %0d checks, %0d errors", name,
             u_check.checks - checks_before, u_check.errors - errors_before);
  endtask

  initial
  begin
    logic [31:0] r;
    issue_v = 1'b0;
    flush = 1'b0;
    op = e_fadd;
    fn = '0;
    frm = e_rne;
    rs1 = '0;
    rs2 = '0;
    rs3 = '0;
    test_id = 4'd0;
    rng_state = 32'd64;
    wait (!reset);
    begin_test(4'd0);
    idle(10);
    end_test("reset_idle");
    begin_test(4'd1);
    repeat (40) imul_op(1'b0);
    end_test("imul");
    begin_test(4'd2);
    repeat (60)
    begin
      next_rand(r);
      float_op(fma_op_e'(3'(r % 3)), 1'b0);
    end
    end_test("addsub_mul");
    begin_test(4'd3);
    repeat (80)
    begin
      next_rand(r);
      if (r % 5 == 4)
        imul_op(1'b0);
      else
        float_op(fma_op_e'(3'(3 + r % 5)), 1'b0);
    end
    end_test("fma_burst");
    begin_test(4'd4);
    special(e_fadd, e_rne, 16'h7E00, 16'h3C00, 16'h0000);
    special(e_fmadd, e_rne, 16'h7C01, 16'h3C00, 16'h3C00);
    special(e_fmul, e_rne, 16'h7C00, 16'h0000, 16'h0000);
    special(e_fsub, e_rne, 16'h7C00, 16'h7C00, 16'h0000);
    special(e_fmul, e_rup, 16'h7BFF, 16'h7BFF, 16'h0000);
    special(e_fmul, e_rne, 16'h0400, 16'h0400, 16'h0000);
    special(e_fsub, e_rdn, 16'h3C00, 16'h3C00, 16'h0000);
    repeat (30)
    begin
      next_rand(r);
      float_op(fma_op_e'(3'(r % 7)), 1'b0);
    end
    end_test("special");
    begin_test(4'd5);
    repeat (4)
    begin
      imul_op(1'b0);
      float_op(e_fmadd, 1'b0);
      float_op(e_fnmadd, 1'b1);
      repeat (3) imul_op(1'b0);
      repeat (3) float_op(e_fmsub, 1'b0);
    end
    end_test("flush");
    $display("total: %0d checks, %0d errors", u_check.checks, u_check.errors);
    if (u_check.errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin
    #((TOTAL_ISSUES + `FMA_LATENCY + 100) * CLK_PERIOD);
    $display("watchdog timeout: the test sequence did not finish in time");
    $display("Errors found");
    $finish;
  end

endmodule

/* fma_pipe.f */
+incdir+rtl
rtl/fma_pkg.sv
rtl/fma_if.sv
rtl/fma_issue_decode.sv
rtl/fma_mul_add_raw.sv
rtl/fma_round.sv
rtl/fma_result_delay.sv
rtl/fma_pipe_top.sv
bench/tb_clock_gen.sv
bench/fma_checker.sv
bench/tb_fma_pipe.sv

/* rtl/fma_if.sv */
// FMA pipe internal buses
`timescale 1ns/1ps
`include "fma_params.svh"

// decoded operation handed to the multiply-add stage
interface fma_issue_if;
  import fma_pkg::*;

  logic                   v;
  logic                   is_imul;
  logic                   opw;
  logic                   neg_prod;
  logic                   neg_add;
  fma_rm_e                rm;
  logic [`FMA_XLEN-1:0]   a;
  logic [`FMA_XLEN-1:0]   b;
  logic [`FMA_HALF_W-1:0] c;

  modport source (output v, is_imul, opw, neg_prod, neg_add, rm, a, b, c);
  modport sink   (input  v, is_imul, opw, neg_prod, neg_add, rm, a, b, c);
endinterface

// unrounded result of the multiply-add stage
interface fma_raw_if;
  import fma_pkg::*;

  logic                          v;
  logic                          is_imul;
  logic                          opw;
  fma_rm_e                       rm;
  logic                          is_nan;
  logic                          invalid;
  logic                          is_inf;
  logic                          is_zero;
  logic                          sign;
  logic signed [`FMA_SEXP_W-1:0] sexp;
  logic [`FMA_SIG_W-1:0]         sig;
  logic [`FMA_XLEN-1:0]          imul_prod;

  modport source (output v, is_imul, opw, rm, is_nan, invalid, is_inf, is_zero,
                  sign, sexp, sig, imul_prod);
  modport sink   (input  v, is_imul, opw, rm, is_nan, invalid, is_inf, is_zero,
                  sign, sexp, sig, imul_prod);
endinterface

/* rtl/fma_issue_decode.sv */
// FMA issue decode
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_issue_decode
  (
    input  logic                 issue_v_i,
    input  fma_pkg::fma_op_e     issue_op_i,
    input  fma_pkg::fma_instr_u  issue_fn_i,
    input  fma_pkg::fma_rm_e     frm_dyn_i,
    input  logic [`FMA_XLEN-1:0] rs1_i,
    input  logic [`FMA_XLEN-1:0] rs2_i,
    input  logic [`FMA_XLEN-1:0] rs3_i,
    input  logic                 flush_i,
    fma_issue_if.source          issue
  );
  import fma_pkg::*;

  localparam int HW = `FMA_HALF_W;
  localparam logic [HW-1:0] HALF_ONE  = 16'h3C00;
  localparam logic [HW-1:0] HALF_ZERO = 16'h0000;

  logic is_imul;
  logic is_addsub;
  logic is_mul;
  logic neg_prod;
  logic neg_add;

  assign is_imul   = (issue_op_i == e_imul);
  assign is_addsub = (issue_op_i == e_fadd) || (issue_op_i == e_fsub);
  assign is_mul    = (issue_op_i == e_fmul);

  // sign controls of the product and of the addend
  always_comb
  begin
    neg_prod = 1'b0;
    neg_add  = 1'b0;
    case (issue_op_i)
      e_fsub, e_fmsub:
        neg_add = 1'b1;
      e_fnmsub:
        neg_prod = 1'b1;
      e_fnmadd:
      begin
        neg_prod = 1'b1;
        neg_add  = 1'b1;
      end
      default:
        neg_add = 1'b0;
    endcase
  end

  // a flush in the issue cycle kills the operation right here
  assign issue.v        = issue_v_i & ~flush_i;
  assign issue.is_imul  = is_imul;
  assign issue.opw      = is_imul & issue_fn_i.imul.opw;
  assign issue.neg_prod = neg_prod;
  assign issue.neg_add  = neg_add;
  assign issue.rm       = (issue_fn_i.rm == e_dyn) ? frm_dyn_i : issue_fn_i.rm;

  // fadd and fsub multiply by one and fmul adds a positive zero
  assign issue.a = rs1_i;
  assign issue.b = is_addsub ? {{(`FMA_XLEN-HW){1'b0}}, HALF_ONE} : rs2_i;
  assign issue.c = is_addsub ? rs2_i[HW-1:0] : (is_mul ? HALF_ZERO : rs3_i[HW-1:0]);

endmodule

/* rtl/fma_mul_add_raw.sv */
// FMA multiply-add stage
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_mul_add_raw
  (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      flush_i,
    fma_issue_if.sink issue,
    fma_raw_if.source raw
  );
  import fma_pkg::*;

  localparam int XL = `FMA_XLEN;
  localparam int HW = `FMA_HALF_W;

  // hidden bit plus fraction, zero exponents read as zero
  function automatic logic [10:0] half_sig(input logic [4:0] e, input logic [9:0] f);
    return (e != 5'd0) ? {1'b1, f} : 11'd0;
  endfunction

  logic              a_s, b_s, c_s;
  logic [4:0]        a_e, b_e, c_e;
  logic [9:0]        a_f, b_f, c_f;
  logic [10:0]       a_sig, b_sig, c_sig;
  logic              a_nan, b_nan, c_nan, a_inf, b_inf, c_inf;
  logic              a_zero, b_zero, c_zero;
  logic [XL-1:0]     mul_a, mul_b, mul_p;
  logic [21:0]       prod, prod_n, big_sig, sml_sig;
  logic signed [7:0] p_exp, c_exp, big_exp, exp_diff;
  logic              p_sgn, c_sgn, eff_sub, c_big;
  logic [4:0]        shamt;
  logic [52:0]       sml_ext;
  logic [25:0]       sml_al;
  logic [27:0]       big_al, sum_raw, sum_neg_val;
  logic [26:0]       sum_mag;
  logic              any_nan, any_snan, prod_inf, prod_zero;
  logic              invalid, is_nan, is_inf, is_zero, sign;

  assign {a_s, a_e, a_f} = issue.a[HW-1:0];
  assign {b_s, b_e, b_f} = issue.b[HW-1:0];
  assign {c_s, c_e, c_f} = issue.c;

  assign a_sig  = half_sig(a_e, a_f);
  assign b_sig  = half_sig(b_e, b_f);
  assign c_sig  = half_sig(c_e, c_f);
  assign a_zero = (a_e == 5'd0);
  assign b_zero = (b_e == 5'd0);
  assign c_zero = (c_e == 5'd0);
  assign a_nan  = (a_e == 5'h1F) && (a_f != 10'd0);
  assign b_nan  = (b_e == 5'h1F) && (b_f != 10'd0);
  assign c_nan  = (c_e == 5'h1F) && (c_f != 10'd0);
  assign a_inf  = (a_e == 5'h1F) && (a_f == 10'd0);
  assign b_inf  = (b_e == 5'h1F) && (b_f == 10'd0);
  assign c_inf  = (c_e == 5'h1F) && (c_f == 10'd0);

  // one multiplier serves both the integer and the significand product
  assign mul_a = issue.is_imul ? issue.a : {{(XL-11){1'b0}}, a_sig};
  assign mul_b = issue.is_imul ? issue.b : {{(XL-11){1'b0}}, b_sig};
  assign mul_p = mul_a * mul_b;

  // move the product top bit to bit 21 so both terms share the same frame
  assign prod   = mul_p[21:0];
  assign prod_n = prod[21] ? prod : {prod[20:0], 1'b0};
  assign p_exp  = $signed({3'b000, a_e}) + $signed({3'b000, b_e}) - 8'sd15
                  + $signed({7'd0, prod[21]});
  assign c_exp  = $signed({3'b000, c_e});
  assign p_sgn  = a_s ^ b_s ^ issue.neg_prod;
  assign c_sgn  = c_s ^ issue.neg_add;
  assign eff_sub = p_sgn ^ c_sgn;

  // a zero term always goes to the shifted side
  assign prod_zero = a_zero | b_zero;
  assign c_big     = prod_zero | (~c_zero & (c_exp > p_exp));
  assign big_sig   = c_big ? {c_sig, 11'd0} : prod_n;
  assign sml_sig   = c_big ? prod_n : {c_sig, 11'd0};
  assign big_exp   = c_big ? c_exp : p_exp;
  assign exp_diff  = c_big ? (c_exp - p_exp) : (p_exp - c_exp);

  always_comb
  begin
    if (exp_diff < 0)
      shamt = 5'd0;
    else if (exp_diff > 8'sd31)
      shamt = 5'd31;
    else
      shamt = exp_diff[4:0];
  end

  // bits that fall below frame bit 1 collapse into the sticky bit
  assign sml_ext = {sml_sig, 31'd0} >> shamt;
  assign sml_al  = {sml_ext[52:28], |sml_ext[27:0]};
  assign big_al  = {2'b00, big_sig, 4'd0};
  assign sum_raw = eff_sub ? (big_al - {2'b00, sml_al}) : (big_al + {2'b00, sml_al});

  // a negative difference only happens with equal exponents and is exact
  assign sum_neg_val = -sum_raw;
  assign sum_mag     = sum_raw[27] ? sum_neg_val[26:0] : sum_raw[26:0];

  assign any_nan  = a_nan | b_nan | c_nan;
  assign any_snan = (a_nan & ~a_f[9]) | (b_nan & ~b_f[9]) | (c_nan & ~c_f[9]);
  assign prod_inf = a_inf | b_inf;
  assign invalid  = any_snan | (a_inf & b_zero) | (b_inf & a_zero)
                    | (~any_nan & prod_inf & c_inf & eff_sub);
  assign is_nan   = any_nan | invalid;
  assign is_inf   = ~is_nan & (prod_inf | c_inf);
  assign is_zero  = prod_zero & c_zero;

  always_comb
  begin
    if (is_inf)
      sign = prod_inf ? p_sgn : c_sgn;
    else if (is_zero)
      sign = (p_sgn == c_sgn) ? p_sgn : (issue.rm == e_rdn);
    else
      sign = (c_big ? c_sgn : p_sgn) ^ sum_raw[27];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
      raw.v <= 1'b0;
    else
      raw.v <= issue.v;
  end

  always_ff @(posedge clk_i)
  begin
    raw.is_imul   <= issue.is_imul;
    raw.opw       <= issue.opw;
    raw.rm        <= issue.rm;
    raw.is_nan    <= is_nan;
    raw.invalid   <= invalid;
    raw.is_inf    <= is_inf;
    raw.is_zero   <= is_zero;
    raw.sign      <= sign;
    raw.sexp      <= big_exp + 8'sd1;
    raw.sig       <= sum_mag[`FMA_SIG_W-1:0];
    raw.imul_prod <= mul_p;
  end

endmodule

/* rtl/fma_params.svh */
// FMA pipe parameters
`ifndef FMA_PARAMS_SVH
`define FMA_PARAMS_SVH

// cycles from an accepted issue to the float result valid
`define FMA_LATENCY 4

// cycles from an accepted issue to the integer result valid
`define IMUL_LATENCY 3

// integer datapath width and half precision word width
`define FMA_XLEN 32
`define FMA_HALF_W 16

// raw sum carries a carry bit, a 22 bit product frame, 3 extension bits and a sticky bit
`define FMA_SIG_W 27

// signed biased exponent of the raw sum
`define FMA_SEXP_W 8

`endif

/* rtl/fma_pipe_top.sv */
// FMA pipe top level
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_pipe_top
  (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   issue_v_i,
    input  fma_pkg::fma_op_e       issue_op_i,
    input  fma_pkg::fma_instr_u    issue_fn_i,
    input  fma_pkg::fma_rm_e       frm_dyn_i,
    input  logic [`FMA_XLEN-1:0]   rs1_i,
    input  logic [`FMA_XLEN-1:0]   rs2_i,
    input  logic [`FMA_XLEN-1:0]   rs3_i,
    output logic [`FMA_XLEN-1:0]   imul_data_o,
    output logic                   imul_v_o,
    output logic [`FMA_HALF_W-1:0] fma_data_o,
    output fma_pkg::fma_fflags_s   fma_fflags_o,
    output logic                   fma_v_o
  );
  import fma_pkg::*;

  fma_issue_if issue_bus ();
  fma_raw_if   raw_bus ();

  // rounded results before the retiming chains
  logic                   imul_v;
  logic                   fma_v;
  logic [`FMA_XLEN-1:0]   imul_data;
  logic [`FMA_HALF_W-1:0] fma_data;
  fma_fflags_s            fma_fflags;

  fma_issue_decode u_decode
    (
      .issue_v_i  (issue_v_i),
      .issue_op_i (issue_op_i),
      .issue_fn_i (issue_fn_i),
      .frm_dyn_i  (frm_dyn_i),
      .rs1_i      (rs1_i),
      .rs2_i      (rs2_i),
      .rs3_i      (rs3_i),
      .flush_i    (flush_i),
      .issue      (issue_bus.source)
    );

  fma_mul_add_raw u_mul_add
    (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .flush_i (flush_i),
      .issue   (issue_bus.sink),
      .raw     (raw_bus.source)
    );

  fma_round u_round
    (
      .raw          (raw_bus.sink),
      .imul_v_o     (imul_v),
      .fma_v_o      (fma_v),
      .imul_data_o  (imul_data),
      .fma_data_o   (fma_data),
      .fma_fflags_o (fma_fflags)
    );

  fma_result_delay u_delay
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flush_i      (flush_i),
      .imul_v_i     (imul_v),
      .fma_v_i      (fma_v),
      .imul_data_i  (imul_data),
      .fma_data_i   (fma_data),
      .fma_fflags_i (fma_fflags),
      .imul_data_o  (imul_data_o),
      .imul_v_o     (imul_v_o),
      .fma_data_o   (fma_data_o),
      .fma_fflags_o (fma_fflags_o),
      .fma_v_o      (fma_v_o)
    );

endmodule

/* rtl/fma_pkg.sv */
// FMA pipe shared types
package fma_pkg;

  // operations accepted by the pipe
  typedef enum logic [2:0] {
    e_fadd   = 3'd0,
    e_fsub   = 3'd1,
    e_fmul   = 3'd2,
    e_fmadd  = 3'd3,
    e_fmsub  = 3'd4,
    e_fnmsub = 3'd5,
    e_fnmadd = 3'd6,
    e_imul   = 3'd7
  } fma_op_e;

  // rounding modes with the usual RISC-V encoding
  typedef enum logic [2:0] {
    e_rne = 3'd0,
    e_rtz = 3'd1,
    e_rdn = 3'd2,
    e_rup = 3'd3,
    e_rmm = 3'd4,
    e_dyn = 3'd7
  } fma_rm_e;

  // accrued exception flags in fflags bit order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fma_fflags_s;

  // function field of an integer multiply
  typedef struct packed {
    logic       opw;
    logic [1:0] spare;
  } fma_imul_fn_s;

  // the same three bits are a rounding field for floats
  typedef union packed {
    fma_rm_e      rm;
    fma_imul_fn_s imul;
  } fma_instr_u;

endpackage

/* rtl/fma_result_delay.sv */
// FMA result delay chains
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_result_delay
  (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   imul_v_i,
    input  logic                   fma_v_i,
    input  logic [`FMA_XLEN-1:0]   imul_data_i,
    input  logic [`FMA_HALF_W-1:0] fma_data_i,
    input  fma_pkg::fma_fflags_s   fma_fflags_i,
    output logic [`FMA_XLEN-1:0]   imul_data_o,
    output logic                   imul_v_o,
    output logic [`FMA_HALF_W-1:0] fma_data_o,
    output fma_pkg::fma_fflags_s   fma_fflags_o,
    output logic                   fma_v_o
  );
  import fma_pkg::*;

  // the multiply-add stage already holds one register of the latency
  localparam int IMUL_STAGES = `IMUL_LATENCY - 1;
  localparam int FMA_STAGES  = `FMA_LATENCY - 1;

  logic [IMUL_STAGES-1:0]  imul_v_q;
  logic [`FMA_XLEN-1:0]    imul_d_q [IMUL_STAGES];
  logic [FMA_STAGES-1:0]   fma_v_q;
  logic [`FMA_HALF_W-1:0]  fma_d_q [FMA_STAGES];
  fma_fflags_s             fma_f_q [FMA_STAGES];

  // a flush empties every stage of both chains
  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      imul_v_q <= '0;
      fma_v_q  <= '0;
    end
    else
    begin
      imul_v_q[0] <= imul_v_i;
      for (int i = 1; i < IMUL_STAGES; i++)
        imul_v_q[i] <= imul_v_q[i-1];
      fma_v_q[0] <= fma_v_i;
      for (int i = 1; i < FMA_STAGES; i++)
        fma_v_q[i] <= fma_v_q[i-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    imul_d_q[0] <= imul_data_i;
    for (int i = 1; i < IMUL_STAGES; i++)
      imul_d_q[i] <= imul_d_q[i-1];
    fma_d_q[0] <= fma_data_i;
    fma_f_q[0] <= fma_fflags_i;
    for (int i = 1; i < FMA_STAGES; i++)
    begin
      fma_d_q[i] <= fma_d_q[i-1];
      fma_f_q[i] <= fma_f_q[i-1];
    end
  end

  assign imul_v_o     = imul_v_q[IMUL_STAGES-1];
  assign imul_data_o  = imul_d_q[IMUL_STAGES-1];
  assign fma_v_o      = fma_v_q[FMA_STAGES-1];
  assign fma_data_o   = fma_d_q[FMA_STAGES-1];
  assign fma_fflags_o = fma_f_q[FMA_STAGES-1];

endmodule

/* rtl/fma_round.sv */
// FMA rounding and result format
`timescale 1ns/1ps
`include "fma_params.svh"

module fma_round
  (
    fma_raw_if.sink                raw,
    output logic                   imul_v_o,
    output logic                   fma_v_o,
    output logic [`FMA_XLEN-1:0]   imul_data_o,
    output logic [`FMA_HALF_W-1:0] fma_data_o,
    output fma_pkg::fma_fflags_s   fma_fflags_o
  );
  import fma_pkg::*;

  localparam int SW = `FMA_SIG_W;
  localparam int EW = `FMA_SEXP_W;
  localparam int XL = `FMA_XLEN;
  localparam int HW = `FMA_HALF_W;

  // leading zero count of the raw significand
  function automatic logic [4:0] lead_zeros(input logic [SW-1:0] x);
    logic [4:0] n;
    n = 5'(SW);
    for (int i = 0; i < SW; i++)
    begin
      if (x[i])
        n = 5'(SW - 1 - i);
    end
    return n;
  endfunction

  logic [4:0]           lz;
  logic [SW-1:0]        norm;
  logic signed [EW-1:0] exp_n;
  logic signed [EW-1:0] exp_r;
  logic                 sig_zero, lsb, guard, sticky, inexact, inc;
  logic [11:0]          mant_r;
  logic                 ovf, unf, to_max;
  logic [HW-1:0]        res;
  fma_fflags_s          fflags;

  assign sig_zero = (raw.sig == '0);
  assign lz       = lead_zeros(raw.sig);
  assign norm     = raw.sig << lz;
  assign exp_n    = raw.sexp - $signed({{(EW-5){1'b0}}, lz});

  // keep 11 bits and look at the guard bit and everything below it
  assign lsb     = norm[SW-11];
  assign guard   = norm[SW-12];
  assign sticky  = |norm[SW-13:0];
  assign inexact = guard | sticky;

  always_comb
  begin
    case (raw.rm)
      e_rtz:   inc = 1'b0;
      e_rdn:   inc = raw.sign & inexact;
      e_rup:   inc = ~raw.sign & inexact;
      e_rmm:   inc = guard;
      default: inc = guard & (sticky | lsb);
    endcase
  end

  // a carry out of the significand bumps the exponent and leaves a zero fraction
  assign mant_r = {1'b0, norm[SW-1 -: 11]} + {11'd0, inc};
  assign exp_r  = exp_n + $signed({{(EW-1){1'b0}}, mant_r[11]});
  assign ovf    = (exp_r > 8'sd30);
  assign unf    = (exp_r < 8'sd1);

  // modes that round toward zero saturate to the largest finite value
  assign to_max = (raw.rm == e_rtz) || ((raw.rm == e_rdn) && !raw.sign)
                  || ((raw.rm == e_rup) && raw.sign);

  always_comb
  begin
    fflags = '0;
    res    = {raw.sign, exp_r[4:0], mant_r[9:0]};
    if (raw.is_nan)
    begin
      res       = 16'h7E00;
      fflags.nv = raw.invalid;
    end
    else if (raw.is_inf)
      res = {raw.sign, 15'h7C00};
    else if (raw.is_zero)
      res = {raw.sign, 15'h0000};
    else if (sig_zero)
      res = {raw.rm == e_rdn, 15'h0000};
    else if (ovf)
    begin
      res       = to_max ? {raw.sign, 15'h7BFF} : {raw.sign, 15'h7C00};
      fflags.of = 1'b1;
      fflags.nx = 1'b1;
    end
    else if (unf)
    begin
      res       = {raw.sign, 15'h0000};
      fflags.uf = 1'b1;
      fflags.nx = 1'b1;
    end
    else
      fflags.nx = inexact;
  end

  assign fma_v_o      = raw.v & ~raw.is_imul;
  assign fma_data_o   = res;
  assign fma_fflags_o = fflags;

  // the word form keeps the low half of the product sign extended
  assign imul_v_o    = raw.v & raw.is_imul;
  assign imul_data_o = raw.opw ? {{(XL-HW){raw.imul_prod[HW-1]}}, raw.imul_prod[HW-1:0]}
                               : raw.imul_prod;

endmodule
